// File: filelist.f
hdl/cpu_pkg.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int NUM_REGS   = 8;
    localparam int REG_IDX_W  = 3;
    localparam int IMM_W      = 16;
    localparam int OPC_W      = 7;
    localparam int INFLIGHT_W = 4;

    // Addresses count words.
    localparam logic [DATA_W-1:0] RESET_PC = '0;

    typedef enum logic [OPC_W-1:0] {
        NOP   = 7'd0,
        ADD   = 7'd1,
        SUB   = 7'd2,
        AND   = 7'd3,
        OR    = 7'd4,
        XOR   = 7'd5,
        ADDI  = 7'd6,
        MOVI  = 7'd7,
        SFL   = 7'd8,
        LOAD  = 7'd9,
        STORE = 7'd10,
        BF    = 7'd11,
        JMP   = 7'd12,
        HALT  = 7'd13
    } opcode_e;

    typedef enum logic [1:0] {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE
    } kind_e;

    // Undefined opcodes are legal and act as NOP.
    typedef struct packed {
        logic [IMM_W-1:0]     imm;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rb;
        logic [REG_IDX_W-1:0] ra;
        logic [OPC_W-1:0]     opcode;
    } instr_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        instr_t            instr;
    } fetch_t;

    typedef struct packed {
        opcode_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    a;
        logic [DATA_W-1:0]    b;
        logic                 fa;
        logic [DATA_W-1:0]    imm;
        logic                 writes_reg;
    } issue_t;

    typedef struct packed {
        kind_e                kind;
        logic                 writes_reg;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    result;
        logic                 flag;
        logic [DATA_W-1:0]    store_data;
    } exec_t;

    typedef struct packed {
        logic                 valid;
        logic                 writes_reg;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    value;
        logic                 flag;
    } wb_t;

endpackage

// File: hdl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic                        clock,
    input  logic                        rst,
    output logic                        imem_req,
    output logic [cpu_pkg::DATA_W-1:0]  imem_addr,
    input  logic                        imem_ack,
    input  logic [cpu_pkg::DATA_W-1:0]  imem_rdata,
    output logic                        dmem_req,
    output logic                        dmem_we,
    output logic [cpu_pkg::DATA_W-1:0]  dmem_addr,
    output logic [cpu_pkg::DATA_W-1:0]  dmem_wdata,
    input  logic                        dmem_ack,
    input  logic [cpu_pkg::DATA_W-1:0]  dmem_rdata,
    output logic                        halted
);
    import cpu_pkg::*;

    logic              fetch_valid;
    logic              fetch_ready;
    fetch_t            fetch_data;
    logic              dec_in_valid;
    logic              dec_in_ready;
    fetch_t            dec_in_data;
    logic              dec_out_valid;
    logic              dec_out_ready;
    issue_t            dec_out_data;
    logic              ex_in_valid;
    logic              ex_in_ready;
    issue_t            ex_in_data;
    logic              ex_out_valid;
    logic              ex_out_ready;
    exec_t             ex_out_data;
    logic              mem_in_valid;
    logic              mem_in_ready;
    exec_t             mem_in_data;
    logic              redirect;
    logic [DATA_W-1:0] redirect_pc;
    wb_t               wb;

    fetch_stage u_fetch (
        .clock, .rst, .redirect, .redirect_pc,
        .imem_req, .imem_addr, .imem_ack, .imem_rdata,
        .out_valid(fetch_valid), .out_ready(fetch_ready), .out_data(fetch_data)
    );

    // A redirect drops whatever fetch has queued.
    pipe_reg #(.payload_t(fetch_t)) fd_reg (
        .clock, .rst, .flush(redirect),
        .in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_data),
        .out_valid(dec_in_valid), .out_ready(dec_in_ready), .out_data(dec_in_data)
    );

    decode_stage u_decode (
        .clock, .rst,
        .in_valid(dec_in_valid), .in_ready(dec_in_ready), .in_data(dec_in_data),
        .out_valid(dec_out_valid), .out_ready(dec_out_ready), .out_data(dec_out_data),
        .redirect, .redirect_pc, .wb, .halted
    );

    pipe_reg #(.payload_t(issue_t)) de_reg (
        .clock, .rst, .flush(1'b0),
        .in_valid(dec_out_valid), .in_ready(dec_out_ready), .in_data(dec_out_data),
        .out_valid(ex_in_valid), .out_ready(ex_in_ready), .out_data(ex_in_data)
    );

    execute_stage u_execute (
        .in_valid(ex_in_valid), .in_ready(ex_in_ready), .in_data(ex_in_data),
        .out_valid(ex_out_valid), .out_ready(ex_out_ready), .out_data(ex_out_data)
    );

    pipe_reg #(.payload_t(exec_t)) em_reg (
        .clock, .rst, .flush(1'b0),
        .in_valid(ex_out_valid), .in_ready(ex_out_ready), .in_data(ex_out_data),
        .out_valid(mem_in_valid), .out_ready(mem_in_ready), .out_data(mem_in_data)
    );

    memory_stage u_memory (
        .clock, .rst,
        .in_valid(mem_in_valid), .in_ready(mem_in_ready), .in_data(mem_in_data),
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_ack, .dmem_rdata, .wb
    );

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  cpu_pkg::fetch_t             in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output cpu_pkg::issue_t             out_data,
    output logic                        redirect,
    output logic [cpu_pkg::DATA_W-1:0]  redirect_pc,
    input  cpu_pkg::wb_t                wb,
    output logic                        halted
);
    import cpu_pkg::*;

    logic [DATA_W-1:0]     reg_file [NUM_REGS];
    logic [NUM_REGS-1:0]   flags;
    logic [NUM_REGS-1:0]   busy;
    logic [INFLIGHT_W-1:0] in_flight;

    instr_t            ins;
    opcode_e           op;
    logic [DATA_W-1:0] imm_ext;
    logic              is_branch;
    logic              is_halt;
    logic              hazard;
    logic              taken;
    logic              writes_reg;
    logic              issue;

    assign ins     = in_data.instr;
    assign op      = (ins.opcode <= HALT) ? opcode_e'(ins.opcode) : NOP;
    assign imm_ext = {{(DATA_W-IMM_W){ins.imm[IMM_W-1]}}, ins.imm};

    assign is_branch = (op == BF) || (op == JMP);
    assign is_halt   = (op == HALT);
    assign hazard    = busy[ins.ra] || busy[ins.rb] || busy[ins.rd];
    assign taken     = (op == JMP) || (op == BF && flags[ins.ra]);

    // HALT stays at the head of fd_reg, so nothing behind it is consumed.
    assign in_ready  = !hazard && !is_halt && (is_branch || out_ready);
    assign out_valid = in_valid && !hazard && !is_halt && !is_branch;
    assign issue     = out_valid && out_ready;

    // Not-taken BF needs no redirect.
    assign redirect    = in_valid && in_ready && taken;
    assign redirect_pc = in_data.pc + imm_ext;

    always_comb
    begin
        case (op)
            ADD, SUB, AND, OR, XOR, ADDI, MOVI, SFL, LOAD:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase
    end

    always_comb
    begin
        out_data.op         = op;
        out_data.rd         = ins.rd;
        out_data.a          = reg_file[ins.ra];
        out_data.b          = reg_file[ins.rb];
        out_data.fa         = flags[ins.ra];
        out_data.imm        = imm_ext;
        out_data.writes_reg = writes_reg;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                reg_file[i] <= '0;
            flags     <= '0;
            busy      <= '0;
            in_flight <= '0;
            halted    <= 1'b0;
        end
        else
        begin
            if (wb.valid && wb.writes_reg)
            begin
                reg_file[wb.rd] <= wb.value;
                flags[wb.rd]    <= wb.flag;
                busy[wb.rd]     <= 1'b0;
            end
            if (issue && writes_reg)
                busy[ins.rd] <= 1'b1;

            in_flight <= in_flight + INFLIGHT_W'(issue) - INFLIGHT_W'(wb.valid);

            // Drained once every issued instruction has retired.
            if (in_valid && is_halt && in_flight == '0)
                halted <= 1'b1;
        end
    end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic            in_valid,
    output logic            in_ready,
    input  cpu_pkg::issue_t in_data,
    output logic            out_valid,
    input  logic            out_ready,
    output cpu_pkg::exec_t  out_data
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] opnd;
    logic [DATA_W:0]   sum;
    logic [DATA_W:0]   diff;
    logic [DATA_W-1:0] bitwise;

    assign in_ready  = out_ready;
    assign out_valid = in_valid;

    // One adder serves ADD, ADDI and the address of LOAD and STORE.
    assign opnd = (in_data.op == ADD) ? in_data.b : in_data.imm;
    assign sum  = {1'b0, in_data.a} + {1'b0, opnd};
    assign diff = {1'b0, in_data.a} - {1'b0, in_data.b};

    always_comb
    begin
        case (in_data.op)
            AND:     bitwise = in_data.a & in_data.b;
            OR:      bitwise = in_data.a | in_data.b;
            default: bitwise = in_data.a ^ in_data.b;
        endcase
    end

    always_comb
    begin
        out_data.kind       = KIND_ALU;
        out_data.writes_reg = in_data.writes_reg;
        out_data.rd         = in_data.rd;
        out_data.store_data = in_data.b;
        out_data.result     = '0;
        out_data.flag       = 1'b0;
        case (in_data.op)
            ADD, ADDI:
            begin
                out_data.result = sum[DATA_W-1:0];
                out_data.flag   = sum[DATA_W];
            end
            SUB:
            begin
                out_data.result = diff[DATA_W-1:0];
                out_data.flag   = diff[DATA_W];
            end
            AND, OR, XOR:
            begin
                out_data.result = bitwise;
                out_data.flag   = (bitwise == '0);
            end
            MOVI:
            begin
                out_data.result = in_data.imm;
                out_data.flag   = (in_data.imm == '0);
            end
            SFL:
            begin
                out_data.result = DATA_W'(in_data.fa);
                out_data.flag   = in_data.fa;
            end
            LOAD:
            begin
                out_data.kind   = KIND_LOAD;
                out_data.result = sum[DATA_W-1:0];
            end
            STORE:
            begin
                out_data.kind   = KIND_STORE;
                out_data.result = sum[DATA_W-1:0];
            end
            default:
                out_data.result = '0;
        endcase
    end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        redirect,
    input  logic [cpu_pkg::DATA_W-1:0]  redirect_pc,
    output logic                        imem_req,
    output logic [cpu_pkg::DATA_W-1:0]  imem_addr,
    input  logic                        imem_ack,
    input  logic [cpu_pkg::DATA_W-1:0]  imem_rdata,
    output logic                        out_valid,
    input  logic                        out_ready,
    output cpu_pkg::fetch_t             out_data
);
    import cpu_pkg::*;

    typedef enum logic {
        F_IDLE,
        F_REQ
    } fstate_e;

    fstate_e           state;
    logic [DATA_W-1:0] pc;
    logic              discard;
    logic              can_start;
    logic              word_done;

    // A new request waits for ack low and a free output slot.
    assign can_start = (state == F_IDLE) && !imem_ack && (!out_valid || out_ready)
                       && !redirect;
    assign word_done = (state == F_REQ) && imem_ack;
    assign imem_req  = (state == F_REQ);

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state     <= F_IDLE;
            pc        <= RESET_PC;
            discard   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (can_start)
            begin
                state <= F_REQ;
                pc    <= pc + DATA_W'(1);
            end
            else if (word_done)
                state <= F_IDLE;

            if (redirect)
                pc <= redirect_pc;

            // Word of an open handshake is wrong path after a redirect.
            if (word_done)
                discard <= 1'b0;
            else if (redirect && state == F_REQ)
                discard <= 1'b1;

            if (redirect)
                out_valid <= 1'b0;
            else if (word_done && !discard)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (can_start)
            imem_addr <= pc;
        if (word_done)
        begin
            out_data.pc    <= imem_addr;
            out_data.instr <= instr_t'(imem_rdata);
        end
    end

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  cpu_pkg::exec_t              in_data,
    output logic                        dmem_req,
    output logic                        dmem_we,
    output logic [cpu_pkg::DATA_W-1:0]  dmem_addr,
    output logic [cpu_pkg::DATA_W-1:0]  dmem_wdata,
    input  logic                        dmem_ack,
    input  logic [cpu_pkg::DATA_W-1:0]  dmem_rdata,
    output cpu_pkg::wb_t                wb
);
    import cpu_pkg::*;

    typedef enum logic {
        M_IDLE,
        M_REQ
    } mstate_e;

    mstate_e state;
    logic    is_mem;
    logic    start;
    logic    retire;

    assign is_mem = (in_data.kind != KIND_ALU);
    assign start  = (state == M_IDLE) && in_valid && is_mem && !dmem_ack;

    // em_reg holds a load or store until its ack arrives.
    assign in_ready = ((state == M_IDLE) && !is_mem) || ((state == M_REQ) && dmem_ack);
    assign retire   = in_valid && in_ready;

    assign dmem_req   = (state == M_REQ);
    assign dmem_we    = (in_data.kind == KIND_STORE);
    assign dmem_addr  = in_data.result;
    assign dmem_wdata = in_data.store_data;

    always_ff @(posedge clock)
    begin
        if (rst)
            state <= M_IDLE;
        else if (start)
            state <= M_REQ;
        else if (state == M_REQ && dmem_ack)
            state <= M_IDLE;
    end

    always_ff @(posedge clock)
    begin
        wb.writes_reg <= in_data.writes_reg;
        wb.rd         <= in_data.rd;
        if (in_data.kind == KIND_LOAD)
        begin
            wb.value <= dmem_rdata;
            wb.flag  <= (dmem_rdata == '0);
        end
        else
        begin
            wb.value <= in_data.result;
            wb.flag  <= in_data.flag;
        end
        if (rst)
            wb.valid <= 1'b0;
        else
            wb.valid <= retire;
    end

endmodule

// File: hdl/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Free when empty or when the held entry leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clock)
    begin
        if (rst || flush)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clock)
    begin
        if (in_valid && in_ready)
            out_data <= in_data;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpu_tb -f filelist.f -o Vcpu_tb

./obj_dir/Vcpu_tb | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/cpu_sva.sv
`timescale 1ns/100ps

module cpu_sva (
    input logic clock,
    input logic rst,
    input logic imem_req,
    input logic imem_ack,
    input logic dmem_req,
    input logic dmem_ack,
    input logic halted
);

    // Four-phase rule. Req holds until acknowledged.
    imem_req_held: assert property (@(posedge clock) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    dmem_req_held: assert property (@(posedge clock) disable iff (rst)
        dmem_req && !dmem_ack |=> dmem_req)
        else $error("dmem_req dropped before dmem_ack");

    // A new request only after the previous ack is low.
    imem_req_after_ack: assert property (@(posedge clock) disable iff (rst)
        $rose(imem_req) |-> !$past(imem_ack))
        else $error("imem_req rose while imem_ack was high");

    dmem_req_after_ack: assert property (@(posedge clock) disable iff (rst)
        $rose(dmem_req) |-> !$past(dmem_ack))
        else $error("dmem_req rose while dmem_ack was high");

    halted_sticky: assert property (@(posedge clock)
        $fell(halted) |-> $past(rst))
        else $error("halted fell without reset");

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    // Five programs of under 60 instructions at up to 12 cycles each with margin.
    localparam int MAX_CYCLES = 5 * 60 * 12 + 400;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    typedef store_t store_q_t [$];

    logic              clock;
    logic              rst;
    logic              imem_req;
    logic [DATA_W-1:0] imem_addr;
    logic              imem_ack;
    logic [DATA_W-1:0] imem_rdata;
    logic              dmem_req;
    logic              dmem_we;
    logic [DATA_W-1:0] dmem_addr;
    logic [DATA_W-1:0] dmem_wdata;
    logic              dmem_ack;
    logic [DATA_W-1:0] dmem_rdata;
    logic              halted;

    logic [31:0] instr_mem [256];
    logic [31:0] data_mem [256];
    store_q_t    exp_q;
    int          wp;
    int          errors;
    int          got_stores;
    int          n_expected;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    cpu_top DUT (.*);

    bind cpu_top cpu_sva u_sva (
        .clock(clock), .rst(rst), .imem_req(imem_req), .imem_ack(imem_ack),
        .dmem_req(dmem_req), .dmem_ack(dmem_ack), .halted(halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, a program did not reach halted", cycles);
        $display(">>> FAIL");
        $finish;
    end

    // Instruction port slave.
    always
    begin : imem_slave
        int unsigned d;
        @(negedge clock);
        if (!rst && imem_req)
        begin
            d = $urandom_range(3, 0);
            repeat (d) @(posedge clock);
            @(posedge clock);
            #1;
            imem_ack   = 1'b1;
            imem_rdata = instr_mem[imem_addr[7:0]];
            while (imem_req)
                @(negedge clock);
            d = $urandom_range(3, 0);
            repeat (d) @(posedge clock);
            @(posedge clock);
            #1;
            imem_ack = 1'b0;
        end
    end

    // Data port slave. Writes land when ack rises.
    always
    begin : dmem_slave
        int unsigned d;
        @(negedge clock);
        if (!rst && dmem_req)
        begin
            d = $urandom_range(3, 0);
            repeat (d) @(posedge clock);
            @(posedge clock);
            #1;
            if (dmem_we)
                data_mem[dmem_addr[7:0]] = dmem_wdata;
            else
                dmem_rdata = data_mem[dmem_addr[7:0]];
            dmem_ack = 1'b1;
            while (dmem_req)
                @(negedge clock);
            d = $urandom_range(3, 0);
            repeat (d) @(posedge clock);
            @(posedge clock);
            #1;
            dmem_ack = 1'b0;
        end
    end

    // Each store is seen once in the cycle before req drops.
    always @(negedge clock)
    begin : store_check
        store_t e;
        if (!rst && dmem_req && dmem_ack && dmem_we)
        begin
            got_stores++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("store to address %h at %0t was not expected", dmem_addr, $time);
            end
            else
            begin
                e = exp_q.pop_front();
                if (dmem_addr !== e.addr)
                begin
                    errors++;
                    $display("ERR %0t dmem_addr expected %h got %h", $time, e.addr, dmem_addr);
                end
                if (dmem_wdata !== e.data)
                begin
                    errors++;
                    $display("ERR %0t dmem_wdata expected %h got %h", $time, e.data,
                             dmem_wdata);
                end
            end
        end
    end

    // Instruction set model on a copy of the data memory.
    function automatic store_q_t ref_run();
        logic [31:0] r [8];
        logic [7:0]  fl;
        logic [31:0] m [256];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] v;
        logic [6:0]  opc;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  rd;
        logic        f;
        logic        wr;
        store_t      st;
        store_q_t    q;
        m  = data_mem;
        fl = '0;
        pc = '0;
        for (int i = 0; i < 8; i++)
            r[i] = '0;
        for (int s = 0; s < 1000; s++)
        begin
            w   = instr_mem[pc[7:0]];
            opc = w[6:0];
            ra  = w[9:7];
            rb  = w[12:10];
            rd  = w[15:13];
            imm = {{16{w[31]}}, w[31:16]};
            ea  = r[ra] + imm;
            nxt = pc + 32'd1;
            wr  = 1'b1;
            v   = '0;
            f   = 1'b0;
            if (opc == HALT)
                break;
            case (opc)
                ADD:  {f, v} = {1'b0, r[ra]} + {1'b0, r[rb]};
                SUB:
                begin
                    v = r[ra] - r[rb];
                    f = (r[ra] < r[rb]);
                end
                AND:
                begin
                    v = r[ra] & r[rb];
                    f = (v == 0);
                end
                OR:
                begin
                    v = r[ra] | r[rb];
                    f = (v == 0);
                end
                XOR:
                begin
                    v = r[ra] ^ r[rb];
                    f = (v == 0);
                end
                ADDI: {f, v} = {1'b0, r[ra]} + {1'b0, imm};
                MOVI:
                begin
                    v = imm;
                    f = (imm == 0);
                end
                SFL:
                begin
                    v = {31'b0, fl[ra]};
                    f = fl[ra];
                end
                LOAD:
                begin
                    v = m[ea[7:0]];
                    f = (v == 0);
                end
                STORE:
                begin
                    wr = 1'b0;
                    m[ea[7:0]] = r[rb];
                    st.addr = ea;
                    st.data = r[rb];
                    q.push_back(st);
                end
                BF:
                begin
                    wr = 1'b0;
                    if (fl[ra])
                        nxt = pc + imm;
                end
                JMP:
                begin
                    wr  = 1'b0;
                    nxt = pc + imm;
                end
                default: wr = 1'b0;
            endcase
            if (wr)
            begin
                r[rd]  = v;
                fl[rd] = f;
            end
            pc = nxt;
        end
        return q;
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < 256; i++)
        begin
            // Unused opcode 0x7f decodes as NOP.
            instr_mem[8'(i)] = {16'(i), 16'h007f};
            data_mem[8'(i)]  = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        wp = 0;
    endtask

    task automatic emit(input opcode_e op, input int rd, input int ra, input int rb,
                        input int imm);
        instr_mem[8'(wp)] = {16'(imm), 3'(rd), 3'(rb), 3'(ra), op};
        wp++;
    endtask

    // Result into r5 and its flag into r6. Both are stored.
    task automatic alu_case(input opcode_e op, input int ra, input int rb, input int imm,
                            input int addr);
        emit(op, 5, ra, rb, imm);
        emit(STORE, 0, 0, 5, addr);
        emit(SFL, 6, 5, 0, 0);
        emit(STORE, 0, 0, 6, addr + 1);
    endtask

    task automatic prog_alu();
        emit(MOVI, 1, 0, 0, $urandom_range(16'hffff, 0));
        emit(MOVI, 2, 0, 0, $urandom_range(16'hffff, 0));
        emit(MOVI, 3, 0, 0, 16'h8000);
        emit(MOVI, 4, 0, 0, 16'hffff);
        alu_case(ADD, 1, 2, 0, 0);
        alu_case(ADD, 3, 3, 0, 2);
        alu_case(SUB, 1, 2, 0, 4);
        alu_case(SUB, 2, 4, 0, 6);
        alu_case(AND, 1, 2, 0, 8);
        alu_case(AND, 1, 0, 0, 10);
        alu_case(OR, 1, 2, 0, 12);
        alu_case(XOR, 1, 1, 0, 14);
        alu_case(XOR, 1, 2, 0, 16);
        alu_case(ADDI, 4, 0, 1, 18);
        alu_case(ADDI, 1, 0, $urandom_range(16'hffff, 0), 20);
        alu_case(MOVI, 0, 0, 0, 22);
        emit(HALT, 0, 0, 0, 0);
    endtask

    task automatic prog_hazard();
        emit(MOVI, 1, 0, 0, $urandom_range(16'hffff, 0));
        emit(ADDI, 2, 1, 0, 5);
        emit(ADD, 3, 2, 1, 0);
        emit(SUB, 4, 3, 2, 0);
        emit(STORE, 0, 0, 4, 40);
        emit(STORE, 0, 0, 3, 41);
        emit(LOAD, 5, 0, 0, 41);
        emit(ADD, 6, 5, 5, 0);
        emit(STORE, 0, 0, 6, 42);
        emit(MOVI, 1, 0, 0, 50);
        emit(STORE, 0, 0, 1, 43);
        emit(LOAD, 2, 0, 0, 43);
        // Address taken straight from a load.
        emit(LOAD, 3, 2, 0, 0);
        emit(XOR, 4, 3, 3, 0);
        emit(SFL, 7, 4, 0, 0);
        emit(STORE, 0, 0, 3, 44);
        emit(STORE, 0, 0, 7, 45);
        emit(STORE, 0, 0, 4, 46);
        emit(HALT, 0, 0, 0, 0);
    endtask

    task automatic prog_mem();
        emit(MOVI, 6, 0, 0, 96);
        for (int k = 1; k <= 4; k++)
            emit(MOVI, k, 0, 0, $urandom_range(16'hffff, 0));
        for (int k = 0; k < 12; k++)
        begin
            if ($urandom_range(1, 0) == 1)
                emit(STORE, 0, 6, 1 + $urandom_range(3, 0), 4 + $urandom_range(15, 0));
            else
            begin
                emit(LOAD, 5, 6, 0, 4 + $urandom_range(15, 0));
                emit(STORE, 0, 0, 5, 200 + k);
            end
        end
        emit(HALT, 0, 0, 0, 0);
    endtask

    task automatic prog_branch();
        int loop_pc;
        emit(MOVI, 1, 0, 0, 0);
        emit(BF, 0, 1, 0, 2);
        emit(STORE, 0, 0, 1, 150);
        emit(MOVI, 2, 0, 0, 5);
        emit(BF, 0, 2, 0, 2);
        emit(STORE, 0, 0, 2, 151);
        emit(JMP, 0, 0, 0, 3);
        emit(STORE, 0, 0, 2, 152);
        emit(STORE, 0, 0, 2, 153);
        // Count r3 up to a random limit in r4.
        emit(MOVI, 3, 0, 0, 0);
        emit(MOVI, 4, 0, 0, $urandom_range(6, 3));
        emit(MOVI, 5, 0, 0, 1);
        loop_pc = wp;
        emit(ADD, 3, 3, 5, 0);
        emit(STORE, 0, 3, 3, 160);
        emit(SUB, 7, 3, 4, 0);
        emit(BF, 0, 7, 0, loop_pc - wp);
        emit(STORE, 0, 0, 3, 170);
        emit(JMP, 0, 0, 0, 3);
        emit(STORE, 0, 0, 2, 171);
        emit(JMP, 0, 0, 0, 3);
        emit(JMP, 0, 0, 0, -2);
        emit(STORE, 0, 0, 2, 172);
        emit(HALT, 0, 0, 0, 0);
    endtask

    task automatic prog_halt();
        emit(MOVI, 1, 0, 0, $urandom_range(16'hffff, 0));
        emit(STORE, 0, 0, 1, 10);
        emit(LOAD, 2, 0, 0, 10);
        emit(ADDI, 3, 2, 0, 1);
        emit(STORE, 0, 0, 3, 11);
        emit(HALT, 0, 0, 0, 0);
        emit(STORE, 0, 0, 1, 12);
        emit(STORE, 0, 0, 2, 13);
        emit(MOVI, 4, 0, 0, 7);
        emit(STORE, 0, 0, 4, 14);
    endtask

    task automatic run_test(input string name);
        int err_before;
        exp_q      = ref_run();
        n_expected = exp_q.size();
        err_before = errors;
        got_stores = 0;
        @(posedge clock);
        #1 rst = 1'b1;
        repeat (4) @(posedge clock);
        #1 rst = 1'b0;
        do
            @(negedge clock);
        while (!halted);
        // An open fetch handshake may still finish.
        repeat (12) @(negedge clock);
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clock);
            if (!halted)
            begin
                errors++;
                $display("halted fell at %0t while the core was stopped", $time);
            end
            if (imem_req || dmem_req)
            begin
                errors++;
                $display("a memory port raised req at %0t after halted", $time);
            end
        end
        if (got_stores != n_expected)
        begin
            errors++;
            $display("ERR %0t store count expected %0d got %0d", $time, n_expected,
                     got_stores);
        end
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("%-8s %s  stores %0d of %0d", name, (errors == err_before) ? "ok" : "FAILED",
                 got_stores, n_expected);
    endtask

    initial
    begin
        void'($urandom(32'h47746bd4));
        rst          = 1'b1;
        imem_ack     = 1'b0;
        imem_rdata   = '0;
        dmem_ack     = 1'b0;
        dmem_rdata   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        got_stores   = 0;
        clear_mem();
        prog_alu();
        run_test("alu");
        clear_mem();
        prog_hazard();
        run_test("hazard");
        clear_mem();
        prog_mem();
        run_test("memory");
        clear_mem();
        prog_branch();
        run_test("branch");
        clear_mem();
        prog_halt();
        run_test("halt");
        $display("tests %0d  failed %0d  errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
